//--- run_sim.sh
#!/usr/bin/env bash
# Builds the UART peripheral testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        -f uart_periph.f --top-module uart_periph_tb -Mdir "$BUILD_DIR"; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$BUILD_DIR/Vuart_periph_tb" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1; then
    cat "$LOG_FILE"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG_FILE"

if grep -q "ALL TESTS PASSED" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

//--- source/uart_periph.sv
`timescale 1ns/1ps

module uart_periph (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_i,
    input  logic                we_i,
    input  logic                sel_i,
    input  logic [5:0]          addr_i,
    input  uart_pkg::bus_data_t wdata_i,
    output uart_pkg::bus_data_t rdata_o,
    output logic                ack_o,
    output logic                irq_o,
    input  logic                rxd_i,
    output logic                txd_o
);
    import uart_pkg::*;

    // Transmit path
    logic       tx_start;
    uart_byte_t tx_byte;
    logic       tx_ready;

    // Receive path
    logic       rx_valid;
    uart_byte_t rx_byte;
    logic       frame_err;

    // Shared configuration
    baud_div_t  baud_div;
    logic       two_stop;

    // Queue handshake
    logic       fifo_pop;
    uart_byte_t fifo_head;
    logic       fifo_empty;
    logic       fifo_full;

    // ------------------------------
    // Register block
    // ------------------------------
    // Word index from byte address bits 5 to 2
    uart_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (req_i),
        .we_i         (we_i),
        .sel_i        (sel_i),
        .addr_i       (addr_i[5:2]),
        .wdata_i      (wdata_i),
        .rdata_o      (rdata_o),
        .ack_o        (ack_o),
        .irq_o        (irq_o),
        .tx_start_o   (tx_start),
        .tx_byte_o    (tx_byte),
        .tx_ready_i   (tx_ready),
        .baud_div_o   (baud_div),
        .two_stop_o   (two_stop),
        .frame_err_i  (frame_err),
        .fifo_pop_o   (fifo_pop),
        .fifo_head_i  (fifo_head),
        .fifo_empty_i (fifo_empty),
        .fifo_full_i  (fifo_full)
    );

    // ------------------------------
    // Serial engines and queue
    // ------------------------------
    uart_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (tx_start),
        .data_i     (tx_byte),
        .baud_div_i (baud_div),
        .two_stop_i (two_stop),
        .ready_o    (tx_ready),
        .txd_o      (txd_o)
    );

    uart_rx u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .rxd_i       (rxd_i),
        .baud_div_i  (baud_div),
        .data_o      (rx_byte),
        .valid_o     (rx_valid),
        .frame_err_o (frame_err)
    );

    // Receive pulse doubles as the push strobe
    uart_rx_fifo u_rx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (rx_valid),
        .data_i  (rx_byte),
        .pop_i   (fifo_pop),
        .head_o  (fifo_head),
        .empty_o (fifo_empty),
        .full_o  (fifo_full)
    );

endmodule

//--- source/uart_pkg.sv
package uart_pkg;

    // ------------------------------
    // Data widths
    // ------------------------------
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [7:0]  uart_byte_t;
    typedef logic [15:0] baud_div_t;

    // Receive queue sizing
    localparam int RX_FIFO_DEPTH = 16;

    // One extra bit so the count can reach the full depth
    typedef logic [$clog2(RX_FIFO_DEPTH):0] fifo_count_t;

    // Baud divisor limits
    localparam baud_div_t BAUD_DIV_RESET = 16'd16;
    localparam baud_div_t BAUD_DIV_MIN   = 16'd4;

    // ------------------------------
    // Register word addresses
    // ------------------------------
    localparam reg_addr_t REG_TXDATA   = 4'd0;
    localparam reg_addr_t REG_RXDATA   = 4'd1;
    localparam reg_addr_t REG_BAUD     = 4'd2;
    localparam reg_addr_t REG_STATUS   = 4'd3;
    localparam reg_addr_t REG_TXCTRL   = 4'd4;
    localparam reg_addr_t REG_INT_MASK = 4'd5;

    // Status bit positions
    localparam int STAT_TX_READY  = 0;
    localparam int STAT_RX_AVAIL  = 1;
    localparam int STAT_RX_FULL   = 2;
    localparam int STAT_FRAME_ERR = 3;

    // ------------------------------
    // FSM states
    // ------------------------------
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

//--- source/uart_regs.sv
`timescale 1ns/1ps

module uart_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_i,
    input  logic                 we_i,
    input  logic                 sel_i,
    input  uart_pkg::reg_addr_t  addr_i,
    input  uart_pkg::bus_data_t  wdata_i,
    output uart_pkg::bus_data_t  rdata_o,
    output logic                 ack_o,
    output logic                 irq_o,
    output logic                 tx_start_o,
    output uart_pkg::uart_byte_t tx_byte_o,
    input  logic                 tx_ready_i,
    output uart_pkg::baud_div_t  baud_div_o,
    output logic                 two_stop_o,
    input  logic                 frame_err_i,
    output logic                 fifo_pop_o,
    input  uart_pkg::uart_byte_t fifo_head_i,
    input  logic                 fifo_empty_i,
    input  logic                 fifo_full_i
);
    import uart_pkg::*;

    // One mask bit per status bit
    localparam int MASK_W = 4;

    logic              ack_q;
    bus_data_t         rdata_q;
    bus_data_t         read_word;
    logic              accept;
    logic              rd_access;
    logic              wr_access;
    baud_div_t         baud_div_q;
    baud_div_t         baud_wr_val;
    logic              two_stop_q;
    logic [MASK_W-1:0] int_mask_q;
    logic [MASK_W-1:0] status;
    logic              frame_err_q;
    logic              irq_q;

    // ------------------------------
    // Bus decode
    // ------------------------------
    // A request still held during its ack cycle is not taken again
    assign accept    = req_i & sel_i & ~ack_q;
    assign rd_access = accept & ~we_i;
    assign wr_access = accept & we_i;

    always_comb begin
        status                 = '0;
        status[STAT_TX_READY]  = tx_ready_i;
        status[STAT_RX_AVAIL]  = ~fifo_empty_i;
        status[STAT_RX_FULL]   = fifo_full_i;
        status[STAT_FRAME_ERR] = frame_err_q;
    end

    // Read word selection
    always_comb begin
        read_word = '0;
        case (addr_i)
            REG_TXDATA: begin
                read_word[31] = ~tx_ready_i;
            end
            REG_RXDATA: begin
                read_word[31] = fifo_empty_i;
                // Empty queue reads back byte zero
                if (!fifo_empty_i) begin
                    read_word[7:0] = fifo_head_i;
                end
            end
            REG_BAUD:     read_word[15:0]       = baud_div_q;
            REG_STATUS:   read_word[MASK_W-1:0] = status;
            REG_TXCTRL:   read_word[0]          = two_stop_q;
            REG_INT_MASK: read_word[MASK_W-1:0] = int_mask_q;
            default:      read_word             = '0;
        endcase
    end

    // Divisors below the minimum are stored as the minimum
    assign baud_wr_val = (wdata_i[15:0] < BAUD_DIV_MIN) ? BAUD_DIV_MIN : wdata_i[15:0];

    // ------------------------------
    // Acknowledge and read data
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    // Zero for writes and idle cycles
    always_ff @(posedge clk) begin
        rdata_q <= rd_access ? read_word : '0;
    end

    // ------------------------------
    // Configuration registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            baud_div_q <= BAUD_DIV_RESET;
            two_stop_q <= 1'b0;
            int_mask_q <= '0;
        end else if (wr_access) begin
            case (addr_i)
                REG_BAUD:     baud_div_q <= baud_wr_val;
                REG_TXCTRL:   two_stop_q <= wdata_i[0];
                REG_INT_MASK: int_mask_q <= wdata_i[MASK_W-1:0];
                default:      ;
            endcase
        end
    end

    // Sticky frame error, a new error wins over the clearing read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_err_q <= 1'b0;
        end else if (frame_err_i) begin
            frame_err_q <= 1'b1;
        end else if (rd_access && addr_i == REG_STATUS) begin
            frame_err_q <= 1'b0;
        end
    end

    // Interrupt lags the status bits by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= |(status & int_mask_q);
        end
    end

    // Strobes to the engines and the queue
    assign tx_start_o = wr_access & (addr_i == REG_TXDATA) & tx_ready_i;
    assign tx_byte_o  = wdata_i[7:0];
    assign fifo_pop_o = rd_access & (addr_i == REG_RXDATA) & ~fifo_empty_i;

    assign rdata_o    = rdata_q;
    assign ack_o      = ack_q;
    assign irq_o      = irq_q;
    assign baud_div_o = baud_div_q;
    assign two_stop_o = two_stop_q;

endmodule

//--- source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rxd_i,
    input  uart_pkg::baud_div_t  baud_div_i,
    output uart_pkg::uart_byte_t data_o,
    output logic                 valid_o,
    output logic                 frame_err_o
);
    import uart_pkg::*;

    logic       rx_meta_q;
    logic       rx_sync_q;
    logic       rx_prev_q;
    logic       start_edge;
    rx_state_e  state_q;
    baud_div_t  baud_cnt_q;
    baud_div_t  bit_target;
    logic       bit_end;
    logic [2:0] bit_idx_q;
    uart_byte_t shift_q;
    logic       valid_q;
    logic       frame_err_q;

    // ------------------------------
    // Input synchronizer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= rxd_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    // Needs a high level first, so a low line after a bad stop bit is ignored
    assign start_edge = rx_prev_q & ~rx_sync_q;

    // Half a period to the start-bit middle, full periods after that
    assign bit_target = (state_q == RX_START) ? (baud_div_i >> 1) - baud_div_t'(1)
                                              : baud_div_i - baud_div_t'(1);
    assign bit_end    = (baud_cnt_q >= bit_target);

    // ------------------------------
    // Receive FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= RX_IDLE;
            baud_cnt_q  <= '0;
            valid_q     <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            valid_q     <= 1'b0;
            frame_err_q <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    if (start_edge) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // False start if the line is back high
                    if (bit_end) begin
                        state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end && bit_idx_q == 3'd7) begin
                        state_q <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        state_q     <= RX_IDLE;
                        valid_q     <= rx_sync_q;
                        frame_err_q <= ~rx_sync_q;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase

            if (state_q == RX_IDLE || bit_end) begin
                baud_cnt_q <= '0;
            end else begin
                baud_cnt_q <= baud_cnt_q + baud_div_t'(1);
            end
        end
    end

    // Data bits shift in from the top, LSB arrives first
    always_ff @(posedge clk) begin
        if (state_q == RX_IDLE) begin
            bit_idx_q <= '0;
        end else if (state_q == RX_DATA && bit_end) begin
            shift_q   <= {rx_sync_q, shift_q[7:1]};
            bit_idx_q <= bit_idx_q + 3'd1;
        end
    end

    assign data_o      = shift_q;
    assign valid_o     = valid_q;
    assign frame_err_o = frame_err_q;

endmodule

//--- source/uart_rx_fifo.sv
`timescale 1ns/1ps

module uart_rx_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push_i,
    input  uart_pkg::uart_byte_t data_i,
    input  logic                 pop_i,
    output uart_pkg::uart_byte_t head_o,
    output logic                 empty_o,
    output logic                 full_o
);
    import uart_pkg::*;

    uart_byte_t                         mem_q [RX_FIFO_DEPTH];
    logic [$clog2(RX_FIFO_DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(RX_FIFO_DEPTH)-1:0]   rd_ptr_q;
    fifo_count_t                        count_q;
    logic                               do_push;
    logic                               do_pop;

    // Full drops the push, empty ignores the pop
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // ------------------------------
    // Pointers and fill level
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Pointers wrap naturally at the power-of-two depth
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + fifo_count_t'(1);
                2'b01:   count_q <= count_q - fifo_count_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    assign head_o  = mem_q[rd_ptr_q];
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == fifo_count_t'(RX_FIFO_DEPTH));

endmodule

//--- source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  uart_pkg::uart_byte_t data_i,
    input  uart_pkg::baud_div_t  baud_div_i,
    input  logic                 two_stop_i,
    output logic                 ready_o,
    output logic                 txd_o
);
    import uart_pkg::*;

    tx_state_e  state_q;
    baud_div_t  baud_cnt_q;
    uart_byte_t shift_q;
    logic [2:0] bit_idx_q;
    logic       two_stop_q;
    logic       second_stop_q;
    logic       bit_end;

    // Greater-or-equal copes with a divisor lowered mid-bit
    assign bit_end = (baud_cnt_q >= baud_div_i - baud_div_t'(1));

    // ------------------------------
    // State and bit counter
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= TX_IDLE;
            baud_cnt_q <= '0;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (start_i) begin
                        state_q <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state_q <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end && bit_idx_q == 3'd7) begin
                        state_q <= TX_STOP;
                    end
                end
                TX_STOP: begin
                    if (bit_end && (!two_stop_q || second_stop_q)) begin
                        state_q <= TX_IDLE;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase

            if (state_q == TX_IDLE || bit_end) begin
                baud_cnt_q <= '0;
            end else begin
                baud_cnt_q <= baud_cnt_q + baud_div_t'(1);
            end
        end
    end

    // Frame payload, captured at start
    always_ff @(posedge clk) begin
        if (state_q == TX_IDLE) begin
            if (start_i) begin
                shift_q    <= data_i;
                two_stop_q <= two_stop_i;
            end
            bit_idx_q     <= '0;
            second_stop_q <= 1'b0;
        end else if (bit_end) begin
            if (state_q == TX_DATA) begin
                shift_q   <= shift_q >> 1;
                bit_idx_q <= bit_idx_q + 3'd1;
            end
            if (state_q == TX_STOP) begin
                second_stop_q <= 1'b1;
            end
        end
    end

    // Line level, LSB first
    always_comb begin
        case (state_q)
            TX_START: txd_o = 1'b0;
            TX_DATA:  txd_o = shift_q[0];
            default:  txd_o = 1'b1;
        endcase
    end

    assign ready_o = (state_q == TX_IDLE);

endmodule

//--- uart_periph.f
source/uart_pkg.sv
source/uart_rx_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_regs.sv
source/uart_periph.sv
verif/uart_periph_asserts.sv
verif/uart_periph_tb.sv

//--- verif/uart_periph_asserts.sv
`timescale 1ns/1ps

module uart_periph_asserts (
    input logic       clk,
    input logic       rst_n,
    input logic       ack_i,
    input logic       txd_i,
    input logic       tx_ready_i,
    input logic       irq_i,
    input logic [3:0] int_mask_i
);

    // Count of failed assertions, read back by the testbench
    int failures = 0;

    // Acknowledge is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack_i |=> !ack_i)
        else begin
            $error("ack_o stayed high for two cycles");
            failures++;
        end

    // Idle line is high
    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) tx_ready_i |-> txd_i)
        else begin
            $error("txd_o low while the transmitter is ready");
            failures++;
        end

    // No interrupt a cycle after a zero mask
    irq_masked: assert property (@(posedge clk) disable iff (!rst_n)
                                 (int_mask_i == 4'h0) |=> !irq_i)
        else begin
            $error("irq_o high with a zero mask");
            failures++;
        end

endmodule

bind uart_periph uart_periph_asserts asserts_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .ack_i      (ack_o),
    .txd_i      (txd_o),
    .tx_ready_i (tx_ready),
    .irq_i      (irq_o),
    .int_mask_i (u_regs.int_mask_q)
);

//--- verif/uart_periph_tb.sv
`timescale 1ns/1ps

module uart_periph_tb;
    import uart_pkg::*;

    localparam int SEED         = 82307;
    localparam int BUS_TIMEOUT  = 10;
    localparam int LINE_TIMEOUT = 200;
    localparam int NUM_TX       = 8;
    localparam int NUM_RX       = 10;
    localparam int NUM_IRQ      = 12;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       req_i;
    logic       we_i;
    logic       sel_i;
    logic [5:0] addr_i;
    bus_data_t  wdata_i;
    bus_data_t  rdata_o;
    logic       ack_o;
    logic       irq_o;
    logic       rxd_i;
    logic       txd_o;

    int errors;
    int tests_run;
    int tests_failed;
    int test_start_errors;

    // Reference model state
    uart_byte_t rx_model[$];
    logic       frame_err_m;
    baud_div_t  baud_m;
    logic       two_stop_m;
    logic [3:0] mask_m;

    always #50 clk = ~clk;

    uart_periph dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (req_i),
        .we_i    (we_i),
        .sel_i   (sel_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .ack_o   (ack_o),
        .irq_o   (irq_o),
        .rxd_i   (rxd_i),
        .txd_o   (txd_o)
    );

    // ------------------------------
    // Reporting
    // ------------------------------
    task automatic report_mismatch(input string what, input bus_data_t got, input bus_data_t exp);
        $display("MISMATCH at %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic start_test();
        test_start_errors = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_start_errors);
        end
    endtask

    // Status the model expects with the transmitter idle
    function automatic logic [3:0] expected_status();
        logic [3:0] s;
        s    = 4'b0001;
        s[1] = (rx_model.size() != 0);
        s[2] = (rx_model.size() == RX_FIFO_DEPTH);
        s[3] = frame_err_m;
        return s;
    endfunction

    // ------------------------------
    // Bus access
    // ------------------------------
    task automatic bus_access(input logic we, input reg_addr_t word, input bus_data_t wdata,
                              output bus_data_t rdata);
        int   waited;
        logic ack_seen;
        @(posedge clk);
        req_i   <= 1'b1;
        sel_i   <= 1'b1;
        we_i    <= we;
        addr_i  <= {word, 2'b00};
        wdata_i <= wdata;
        waited   = 0;
        // First negedge lies in the request cycle itself
        @(negedge clk);
        ack_seen = (ack_o === 1'b1);
        while (!ack_seen && waited < BUS_TIMEOUT) begin
            @(negedge clk);
            waited++;
            ack_seen = (ack_o === 1'b1);
        end
        if (!ack_seen) begin
            report_error("no acknowledge from the DUT on a bus access");
        end else if (waited != 1) begin
            report_mismatch("ack latency in cycles", 32'(waited), 32'd1);
        end
        rdata = rdata_o;
        @(posedge clk);
        req_i <= 1'b0;
        sel_i <= 1'b0;
        we_i  <= 1'b0;
    endtask

    task automatic bus_write(input reg_addr_t word, input bus_data_t wdata);
        bus_data_t rd;
        bus_access(1'b1, word, wdata, rd);
        if (rd !== 32'h0) begin
            report_mismatch("read data during a write", rd, 32'h0);
        end
    endtask

    task automatic read_check(input reg_addr_t word, input bus_data_t exp, input string what);
        bus_data_t rd;
        bus_access(1'b0, word, 32'h0, rd);
        if (rd !== exp) begin
            report_mismatch(what, rd, exp);
        end
    endtask

    task automatic read_rxdata_check();
        bus_data_t exp;
        if (rx_model.size() == 0) begin
            exp = 32'h8000_0000;
        end else begin
            exp = {24'h0, rx_model.pop_front()};
        end
        read_check(REG_RXDATA, exp, "RXDATA");
    endtask

    // Reading STATUS clears the sticky frame error
    task automatic read_status_check();
        read_check(REG_STATUS, {28'h0, expected_status()}, "STATUS");
        frame_err_m = 1'b0;
    endtask

    task automatic set_baud(input int div);
        bus_write(REG_BAUD, 32'(div));
        baud_m = baud_div_t'(div);
    endtask

    // ------------------------------
    // Serial line models
    // ------------------------------
    task automatic send_frame(input uart_byte_t b, input int div, input logic stop_bit);
        int i;
        @(posedge clk);
        rxd_i <= 1'b0;
        repeat (div) @(posedge clk);
        for (i = 0; i < 8; i++) begin
            rxd_i <= b[i];
            repeat (div) @(posedge clk);
        end
        rxd_i <= stop_bit;
        repeat (div) @(posedge clk);
        rxd_i <= 1'b1;
        repeat (4) @(posedge clk);
    endtask

    task automatic receive_byte(input uart_byte_t b, input int div, input logic good);
        send_frame(b, div, good);
        if (!good) begin
            frame_err_m = 1'b1;
        end else if (rx_model.size() < RX_FIFO_DEPTH) begin
            rx_model.push_back(b);
        end
    endtask

    // Decodes txd_o at mid-bit and measures the stop length up to tx_ready
    task automatic monitor_tx(input int div, output uart_byte_t got, output int stop_cycles);
        int waited;
        int cnt;
        int i;
        got         = '0;
        stop_cycles = 0;
        waited      = 0;
        @(negedge clk);
        while (txd_o !== 1'b0 && waited < LINE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (txd_o !== 1'b0) begin
            report_error("no start bit seen on txd_o");
        end else begin
            repeat (div / 2) @(negedge clk);
            if (txd_o !== 1'b0) begin
                report_mismatch("start bit level", 32'(txd_o), 32'h0);
            end
            for (i = 0; i < 8; i++) begin
                repeat (div) @(negedge clk);
                got[i] = txd_o;
            end
            cnt = div / 2 + 8 * div;
            while (dut_i.tx_ready !== 1'b1 && cnt < 11 * div + 10) begin
                @(negedge clk);
                cnt++;
                if (cnt >= 9 * div && dut_i.tx_ready !== 1'b1 && txd_o !== 1'b1) begin
                    report_mismatch("stop bit level", 32'(txd_o), 32'h1);
                end
            end
            if (dut_i.tx_ready !== 1'b1) begin
                report_error("transmitter never returned to ready");
            end
            stop_cycles = cnt - 9 * div;
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_registers();
        bus_data_t wdata;
        bus_data_t exp;
        int        i;
        start_test();
        @(negedge clk);
        if (irq_o !== 1'b0) begin
            report_error("irq_o is not low after reset");
        end
        if (txd_o !== 1'b1) begin
            report_error("txd_o is not high after reset");
        end
        read_check(REG_TXDATA, 32'h0, "TXDATA after reset");
        read_check(REG_RXDATA, 32'h8000_0000, "RXDATA after reset");
        read_check(REG_BAUD, 32'd16, "BAUD after reset");
        read_check(REG_STATUS, 32'h1, "STATUS after reset");
        read_check(REG_TXCTRL, 32'h0, "TXCTRL after reset");
        read_check(REG_INT_MASK, 32'h0, "INT_MASK after reset");
        read_check(4'd9, 32'h0, "unmapped word");
        for (i = 0; i < 10; i++) begin
            wdata       = $urandom;
            wdata[15:0] = 16'($urandom_range(24, 0));
            bus_write(REG_BAUD, wdata);
            exp = (wdata[15:0] < 16'd4) ? 32'd4 : {16'h0, wdata[15:0]};
            read_check(REG_BAUD, exp, "BAUD readback");
            wdata = $urandom;
            bus_write(REG_TXCTRL, wdata);
            read_check(REG_TXCTRL, {31'h0, wdata[0]}, "TXCTRL readback");
            wdata = $urandom;
            bus_write(REG_INT_MASK, wdata);
            read_check(REG_INT_MASK, {28'h0, wdata[3:0]}, "INT_MASK readback");
        end
        bus_write(REG_INT_MASK, 32'h0);
        mask_m = 4'h0;
        finish_test("registers");
    endtask

    task automatic test_transmit();
        uart_byte_t sent;
        uart_byte_t got;
        int         div;
        int         stop_cycles;
        int         i;
        start_test();
        for (i = 0; i < NUM_TX; i++) begin
            div        = $urandom_range(20, 4);
            two_stop_m = 1'($urandom_range(1, 0));
            set_baud(div);
            bus_write(REG_TXCTRL, {31'h0, two_stop_m});
            sent = 8'($urandom);
            fork
                monitor_tx(div, got, stop_cycles);
                begin
                    bus_write(REG_TXDATA, {24'h0, sent});
                    read_check(REG_TXDATA, 32'h8000_0000, "TXDATA busy during frame");
                end
            join
            if (got !== sent) begin
                report_mismatch("transmitted byte", {24'h0, got}, {24'h0, sent});
            end
            if (stop_cycles != (two_stop_m ? 2 * div : div)) begin
                report_mismatch("stop interval in cycles", 32'(stop_cycles),
                                32'(two_stop_m ? 2 * div : div));
            end
        end
        read_check(REG_TXDATA, 32'h0, "TXDATA after frames");
        finish_test("transmit");
    endtask

    task automatic test_receive();
        int i;
        start_test();
        set_baud($urandom_range(20, 4));
        for (i = 0; i < NUM_RX; i++) begin
            receive_byte(8'($urandom), int'(baud_m), 1'b1);
        end
        read_status_check();
        while (rx_model.size() > 0) begin
            read_rxdata_check();
        end
        read_rxdata_check();
        finish_test("receive");
    endtask

    task automatic test_overflow();
        int i;
        start_test();
        set_baud($urandom_range(8, 4));
        for (i = 0; i < RX_FIFO_DEPTH + 3; i++) begin
            receive_byte(8'($urandom), int'(baud_m), 1'b1);
        end
        read_status_check();
        repeat (RX_FIFO_DEPTH) read_rxdata_check();
        read_rxdata_check();
        read_status_check();
        finish_test("overflow");
    endtask

    task automatic test_frame_error();
        start_test();
        receive_byte(8'($urandom), int'(baud_m), 1'b0);
        read_status_check();
        read_status_check();
        read_rxdata_check();
        finish_test("frame_error");
    endtask

    task automatic test_interrupt();
        logic [3:0] mask;
        int         i;
        start_test();
        set_baud(6);
        for (i = 0; i < NUM_IRQ; i++) begin
            case ($urandom_range(3, 0))
                0:       receive_byte(8'($urandom), int'(baud_m), 1'b1);
                1:       receive_byte(8'($urandom), int'(baud_m), 1'b0);
                2:       read_rxdata_check();
                default: read_status_check();
            endcase
            mask = 4'($urandom_range(15, 0));
            bus_write(REG_INT_MASK, {28'h0, mask});
            mask_m = mask;
            // One registered cycle plus an idle one
            repeat (2) @(negedge clk);
            if (irq_o !== |(expected_status() & mask_m)) begin
                report_mismatch("irq_o", 32'(irq_o), 32'(|(expected_status() & mask_m)));
            end
        end
        bus_write(REG_INT_MASK, 32'h0);
        mask_m = 4'h0;
        repeat (2) @(negedge clk);
        if (irq_o !== 1'b0) begin
            report_mismatch("irq_o with zero mask", 32'(irq_o), 32'h0);
        end
        finish_test("interrupt");
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        void'($urandom(SEED));
        errors      = 0;
        tests_run   = 0;
        tests_failed = 0;
        frame_err_m = 1'b0;
        baud_m      = 16'd16;
        two_stop_m  = 1'b0;
        mask_m      = 4'h0;
        rst_n   <= 1'b0;
        req_i   <= 1'b0;
        we_i    <= 1'b0;
        sel_i   <= 1'b0;
        addr_i  <= '0;
        wdata_i <= '0;
        rxd_i   <= 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        test_registers();
        test_transmit();
        test_receive();
        test_overflow();
        test_frame_error();
        test_interrupt();

        if (dut_i.asserts_i.failures != 0) begin
            report_error("concurrent assertions failed during the run");
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
